// ==== Bender.yml ====
package:
  name: ps_frag_link

sources:
  # packages first, then the stages and the top level
  - files:
      - hdl/ps_stream_pkg.sv
      - hdl/ps_frag_pkg.sv
      - hdl/ps_fragmenter_packer.sv
      - hdl/ps_width_expander.sv
      - hdl/ds_width_divider.sv
      - hdl/ps_defragmenter_unpacker.sv
      - hdl/ps_frag_link.sv

  # testbench
  - target: test
    files:
      - dv/ps_frag_link_tb.sv

// ==== dv/ps_frag_link_tb.sv ====
`timescale 1ns/100ps

module ps_frag_link_tb;

    localparam int          WIDTH       = 8;
    localparam int          LENGTH      = 16;
    localparam int          ALIGN       = 8;
    localparam int          NUM_PKTS    = 200;
    localparam int          STALL_LIMIT = 2000;     // cycles a word may wait for i_rdy
    localparam int          DRAIN_LIMIT = 5000;     // cycles for the pipeline to empty
    localparam logic [31:0] SEED        = 32'h63c85f3a;

    logic               clk;
    logic               i_arst_n;
    logic [WIDTH-1:0]   i_dat;
    logic               i_val;
    logic               i_eop;
    logic               i_rdy;
    logic [WIDTH-1:0]   o_dat;
    logic               o_val;
    logic               o_eop;
    logic               o_rdy;

    logic [WIDTH:0]     model_q [$];        // {eop, dat} in input order
    logic [31:0]        stim_seed;          // lengths, data, gaps
    logic [31:0]        bp_seed;            // o_rdy pattern
    logic               hold_r;             // o_val high and o_rdy low last edge
    logic [WIDTH-1:0]   hold_dat;
    logic               hold_eop;

    ps_frag_link #(
        .WIDTH   (WIDTH),
        .LENGTH  (LENGTH),
        .ALIGN   (ALIGN),
        .RAMTYPE ("AUTO")
    ) UUT (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_dat    (i_dat),
        .i_val    (i_val),
        .i_eop    (i_eop),
        .i_rdy    (i_rdy),
        .o_dat    (o_dat),
        .o_val    (o_val),
        .o_eop    (o_eop),
        .o_rdy    (o_rdy)
    );

    // ------------------------------
    // helpers
    // ------------------------------
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;    // numerical recipes constants
    endfunction

    // lengths around the fragment and beat boundaries
    function automatic int edge_length(input int idx);
        case (idx % 7)
            0:       return 1;
            1:       return LENGTH;                 // one full fragment
            2:       return LENGTH + 1;             // second fragment of one word
            3:       return ALIGN - 1;              // header + data fill one beat
            4:       return 2 * ALIGN - 1;          // exactly two beats
            5:       return LENGTH + ALIGN - 1;     // tail fragment fills one beat
            default: return 2 * LENGTH;
        endcase
    endfunction

    task automatic stop_test();
        $display("Test FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic mismatch_error(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
        $display("[FAIL] %0t ns: %s expected 0x%0h, actual 0x%0h", $time, name, exp, act);
        stop_test();
    endtask

    task automatic general_error(input string what);
        $display("ERROR at %0t ns: %s", $time, what);
        stop_test();
    endtask

    // ------------------------------
    // clock and back-pressure
    // ------------------------------
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                      // 4 ns period
    end

    always @(posedge clk) begin
        if (i_arst_n) begin
            bp_seed = lcg_next(bp_seed);
            o_rdy <= (bp_seed[27:24] > 4'd4);       // ready about two thirds of the time
        end
    end

    // ------------------------------
    // model and output checks
    // ------------------------------
    always @(posedge clk) begin
        if (i_arst_n && i_val && i_rdy)
            model_q.push_back({i_eop, i_dat});      // word accepted by the DUT
    end

    always @(posedge clk) begin
        logic [WIDTH:0] want;
        if (i_arst_n) begin
            if (hold_r) begin                       // stalled word must not move
                assert (o_val == 1'b1) else mismatch_error("o_val", 1, o_val);
                assert (o_dat == hold_dat) else mismatch_error("o_dat", hold_dat, o_dat);
                assert (o_eop == hold_eop) else mismatch_error("o_eop", hold_eop, o_eop);
            end
            if (o_val && o_rdy) begin
                assert (model_q.size() > 0)
                    else general_error("output word appeared with no input word left");
                want = model_q.pop_front();
                assert (o_dat == want[WIDTH-1:0])
                    else mismatch_error("o_dat", want[WIDTH-1:0], o_dat);
                assert (o_eop == want[WIDTH])
                    else mismatch_error("o_eop", want[WIDTH], o_eop);
            end
            hold_r   <= o_val & ~o_rdy;
            hold_dat <= o_dat;
            hold_eop <= o_eop;
        end
    end

    // ------------------------------
    // stimulus
    // ------------------------------
    initial begin
        int len;
        int t;
        i_arst_n  = 1'b0;
        i_dat     = '0;
        i_val     = 1'b0;
        i_eop     = 1'b0;
        o_rdy     = 1'b0;
        stim_seed = SEED;
        bp_seed   = ~SEED;                          // separate stream for o_rdy
        hold_r    = 1'b0;
        hold_dat  = '0;
        hold_eop  = 1'b0;

        repeat (2) @(posedge clk);
        assert (o_val == 1'b0) else mismatch_error("o_val", 0, o_val);
        assert (i_rdy == 1'b1) else mismatch_error("i_rdy", 1, i_rdy);
        i_arst_n <= 1'b1;

        for (int p = 0; p < NUM_PKTS; p++) begin
            if (p % 4 == 3) begin
                len = edge_length(p / 4);           // forced edge case
            end else begin
                stim_seed = lcg_next(stim_seed);
                len = int'(stim_seed[23:8] % 70) + 1;
            end
            for (int w = 0; w < len; w++) begin
                stim_seed = lcg_next(stim_seed);
                if (stim_seed[31]) begin            // idle gap of 0 to 3 cycles
                    i_val <= 1'b0;
                    repeat (stim_seed[30:29]) @(posedge clk);
                end
                i_dat <= stim_seed[15:8];
                i_eop <= (w == len - 1);
                i_val <= 1'b1;
                t = 0;
                do begin                            // hold until accepted
                    @(posedge clk);
                    t++;
                    assert (t <= STALL_LIMIT)
                        else general_error("input stalled, i_rdy stayed low too long");
                end while (!i_rdy);
            end
        end
        i_val <= 1'b0;
        i_eop <= 1'b0;

        // wait for the last packets to leave
        t = 0;
        do begin
            @(posedge clk);
            t++;
        end while (model_q.size() > 0 && t < DRAIN_LIMIT);

        if (model_q.size() == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            general_error("timeout, words still missing at the output after the drain wait");
        end
    end

endmodule : ps_frag_link_tb

// ==== hdl/ds_width_divider.sv ====
`timescale 1ns/100ps

module ds_width_divider #(
    parameter int IWIDTH = 64,              // wide beat width
    parameter int FACTOR = 8                // narrow words per beat
) (
    input  logic                       clk,
    input  logic                       i_arst_n,

    input  logic [IWIDTH-1:0]          i_dat,
    input  logic                       i_val,
    output logic                       i_rdy,

    output logic [IWIDTH/FACTOR-1:0]   o_dat,
    output logic                       o_val,
    input  logic                       o_rdy
);

    localparam int OWIDTH = IWIDTH / FACTOR;
    localparam int CW     = $clog2(FACTOR + 1);

    logic [IWIDTH-1:0]   shreg;             // low word goes out first
    logic [CW-1:0]       cnt;               // words left in shreg

    // accept when empty or the last word is leaving
    assign i_rdy = (cnt == '0) | ((cnt == CW'(1)) & o_rdy);
    assign o_val = (cnt != '0);
    assign o_dat = shreg[OWIDTH-1:0];

    // ------------------------------
    // shift register
    // ------------------------------
    always_ff @(posedge clk) begin
        if (i_val && i_rdy)
            shreg <= i_dat;
        else if (o_val && o_rdy)
            shreg <= shreg >> OWIDTH;       // next lane down
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            cnt <= '0;
        end else begin
            if (i_val && i_rdy)
                cnt <= CW'(FACTOR);         // full beat loaded
            else if (o_val && o_rdy)
                cnt <= cnt - 1'b1;
        end
    end

endmodule : ds_width_divider

// ==== hdl/ps_defragmenter_unpacker.sv ====
`timescale 1ns/100ps

module ps_defragmenter_unpacker
    import ps_frag_pkg::*;
#(
    parameter int WIDTH = 8,                // word width, at least 8
    parameter int ALIGN = 8                 // fragment alignment in words
) (
    input  logic               clk,
    input  logic               i_arst_n,

    // fragment stream in, no eop
    input  logic [WIDTH-1:0]   i_dat,
    input  logic               i_val,
    output logic               i_rdy,

    // packet stream out
    output logic [WIDTH-1:0]   o_dat,
    output logic               o_val,
    output logic               o_eop,
    input  logic               o_rdy
);

    localparam int PW = (ALIGN > 1) ? $clog2(ALIGN) : 1;

    // ------------------------------
    // signals
    // ------------------------------
    unpacker_state_t    state;
    frag_hdr_t          hdr_r;              // len counts down in DATA
    logic [PW-1:0]      pos_cnt;            // word position inside the beat
    logic               pos_wrap;
    logic               i_xfer;
    logic               data_last;

    assign pos_wrap  = (pos_cnt == PW'(ALIGN - 1));   // last word of a beat
    assign data_last = (hdr_r.len == '0);

    // ------------------------------
    // handshake
    // ------------------------------
    assign i_rdy  = (state == UP_DATA) ? o_rdy : 1'b1;  // header and pad dropped
    assign i_xfer = i_val & i_rdy;

    assign o_dat = i_dat;
    assign o_val = (state == UP_DATA) & i_val;
    assign o_eop = (state == UP_DATA) & data_last & hdr_r.last;

    // ------------------------------
    // control
    // ------------------------------
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state   <= UP_HEAD;
            hdr_r   <= '0;
            pos_cnt <= '0;
        end else begin
            if (i_xfer)
                pos_cnt <= pos_wrap ? '0 : pos_cnt + 1'b1;

            case (state)
                UP_HEAD: begin
                    if (i_xfer) begin
                        hdr_r <= frag_hdr_t'(i_dat[$bits(frag_hdr_t)-1:0]);
                        state <= UP_DATA;
                    end
                end
                UP_DATA: begin
                    if (i_xfer) begin
                        if (data_last)
                            state <= pos_wrap ? UP_HEAD : UP_PAD;
                        else
                            hdr_r.len <= hdr_r.len - 1'b1;
                    end
                end
                UP_PAD: begin
                    if (i_xfer && pos_wrap)     // beat boundary reached
                        state <= UP_HEAD;
                end
                default: state <= UP_HEAD;
            endcase
        end
    end

endmodule : ps_defragmenter_unpacker

// ==== hdl/ps_frag_link.sv ====
`timescale 1ns/100ps

module ps_frag_link
    import ps_stream_pkg::*;
#(
    parameter int    WIDTH   = PS_WIDTH,
    parameter int    LENGTH  = FRAG_LENGTH_DEF,
    parameter int    ALIGN   = FRAG_ALIGN_DEF,   // 2 to 8
    parameter string RAMTYPE = "AUTO"
) (
    input  logic               clk,
    input  logic               i_arst_n,

    input  logic [WIDTH-1:0]   i_dat,
    input  logic               i_val,
    input  logic               i_eop,
    output logic               i_rdy,

    output logic [WIDTH-1:0]   o_dat,
    output logic               o_val,
    output logic               o_eop,
    input  logic               o_rdy
);

    // ------------------------------
    // inter-stage links
    // ------------------------------
    logic [WIDTH-1:0]         pack_dat;     // fragments with headers
    logic                     pack_val;
    logic                     pack_eop;     // end of fragment
    logic                     pack_rdy;

    logic [ALIGN*WIDTH-1:0]   ds_dat;       // wide beats
    logic                     ds_val;
    logic                     ds_rdy;

    logic [WIDTH-1:0]         unpack_dat;   // padded word stream
    logic                     unpack_val;
    logic                     unpack_rdy;

    ps_fragmenter_packer #(
        .WIDTH   (WIDTH),
        .LENGTH  (LENGTH),
        .RAMTYPE (RAMTYPE)
    ) u_packer (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_dat    (i_dat),
        .i_val    (i_val),
        .i_eop    (i_eop),
        .i_rdy    (i_rdy),
        .o_dat    (pack_dat),
        .o_val    (pack_val),
        .o_eop    (pack_eop),
        .o_rdy    (pack_rdy)
    );

    ps_width_expander #(
        .WIDTH (WIDTH),
        .COUNT (ALIGN)
    ) u_expander (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_dat    (pack_dat),
        .i_val    (pack_val),
        .i_eop    (pack_eop),
        .i_rdy    (pack_rdy),
        .o_dat    (ds_dat),
        .o_mty    (),                       // padding is found from the header
        .o_val    (ds_val),
        .o_eop    (),
        .o_rdy    (ds_rdy)
    );

    ds_width_divider #(
        .IWIDTH (WIDTH * ALIGN),
        .FACTOR (ALIGN)
    ) u_divider (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_dat    (ds_dat),
        .i_val    (ds_val),
        .i_rdy    (ds_rdy),
        .o_dat    (unpack_dat),
        .o_val    (unpack_val),
        .o_rdy    (unpack_rdy)
    );

    ps_defragmenter_unpacker #(
        .WIDTH (WIDTH),
        .ALIGN (ALIGN)
    ) u_unpacker (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_dat    (unpack_dat),
        .i_val    (unpack_val),
        .i_rdy    (unpack_rdy),
        .o_dat    (o_dat),
        .o_val    (o_val),
        .o_eop    (o_eop),
        .o_rdy    (o_rdy)
    );

endmodule : ps_frag_link

// ==== hdl/ps_frag_pkg.sv ====
package ps_frag_pkg;

    // ------------------------------
    // fragment header
    // ------------------------------

    // fragment length minus one, LENGTH up to 128
    typedef logic [6:0] frag_len_t;

    // sits in the low 8 bits of the header word
    typedef struct packed {
        logic      last;                    // fragment ends the packet
        frag_len_t len;                     // data words minus one
    } frag_hdr_t;

    // ------------------------------
    // state machines
    // ------------------------------

    // fragmenter control
    typedef enum logic [1:0] {
        PK_FILL,                            // collecting words into the buffer
        PK_HEAD,                            // header word offered
        PK_SEND                             // buffer drains
    } packer_state_t;

    // defragmenter control
    typedef enum logic [1:0] {
        UP_HEAD,                            // waiting for a header word
        UP_DATA,                            // payload passes through
        UP_PAD                              // alignment words dropped
    } unpacker_state_t;

endpackage : ps_frag_pkg

// ==== hdl/ps_fragmenter_packer.sv ====
`timescale 1ns/100ps

module ps_fragmenter_packer
    import ps_frag_pkg::*;
#(
    parameter int    WIDTH   = 8,           // word width, at least 8
    parameter int    LENGTH  = 16,          // max data words per fragment
    parameter string RAMTYPE = "AUTO"       // memory style of the buffer
) (
    input  logic               clk,
    input  logic               i_arst_n,

    // packet stream in
    input  logic [WIDTH-1:0]   i_dat,
    input  logic               i_val,
    input  logic               i_eop,
    output logic               i_rdy,

    // fragment stream out
    output logic [WIDTH-1:0]   o_dat,
    output logic               o_val,
    output logic               o_eop,
    input  logic               o_rdy
);

    localparam int AW = (LENGTH > 1) ? $clog2(LENGTH) : 1;

    // ------------------------------
    // signals
    // ------------------------------
    (* ramstyle = RAMTYPE *)
    logic [WIDTH-1:0]   mem [LENGTH];       // fragment buffer

    packer_state_t      state;
    logic [AW-1:0]      wr_cnt;             // next write slot
    logic [AW-1:0]      rd_cnt;             // next word to send
    frag_hdr_t          hdr_r;              // header of the buffered fragment
    logic [WIDTH-1:0]   hdr_word;

    logic               wr_en;
    logic               frag_full;
    logic               rd_last;
    logic               o_xfer;

    // ------------------------------
    // handshake and flags
    // ------------------------------
    assign i_rdy     = (state == PK_FILL);
    assign wr_en     = i_val & i_rdy;
    assign frag_full = (wr_cnt == AW'(LENGTH - 1));

    assign o_val   = (state != PK_FILL);
    assign o_xfer  = o_val & o_rdy;
    assign rd_last = (frag_len_t'(rd_cnt) == hdr_r.len);   // final data word
    assign o_eop   = (state == PK_SEND) & rd_last;

    // header in the low bits, upper bits zero
    always_comb begin
        hdr_word = '0;
        hdr_word[$bits(frag_hdr_t)-1:0] = hdr_r;
    end

    assign o_dat = (state == PK_HEAD) ? hdr_word : mem[rd_cnt];

    // ------------------------------
    // buffer write
    // ------------------------------
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_cnt] <= i_dat;
        end
    end

    // ------------------------------
    // control
    // ------------------------------
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state  <= PK_FILL;
            wr_cnt <= '0;
            rd_cnt <= '0;
            hdr_r  <= '0;
        end else begin
            case (state)
                PK_FILL: begin
                    if (wr_en) begin
                        if (i_eop || frag_full) begin    // fragment closed
                            state     <= PK_HEAD;
                            hdr_r.last <= i_eop;
                            hdr_r.len  <= frag_len_t'(wr_cnt);
                        end else begin
                            wr_cnt <= wr_cnt + 1'b1;
                        end
                    end
                end
                PK_HEAD: begin
                    if (o_xfer) begin
                        state  <= PK_SEND;
                        rd_cnt <= '0;
                    end
                end
                PK_SEND: begin
                    if (o_xfer) begin
                        if (rd_last) begin               // buffer empty again
                            state  <= PK_FILL;
                            wr_cnt <= '0;
                        end else begin
                            rd_cnt <= rd_cnt + 1'b1;
                        end
                    end
                end
                default: state <= PK_FILL;
            endcase
        end
    end

endmodule : ps_fragmenter_packer

// ==== hdl/ps_stream_pkg.sv ====
package ps_stream_pkg;

    // ------------------------------
    // stream defaults
    // ------------------------------
    localparam int PS_WIDTH        = 8;     // narrow word width
    localparam int FRAG_LENGTH_DEF = 16;    // max data words per fragment
    localparam int FRAG_ALIGN_DEF  = 8;     // words per wide beat

    // ------------------------------
    // wide beat side info
    // ------------------------------

    // empty lanes in a wide beat, up to 7
    typedef logic [2:0] ps_mty_t;

    // side info of the beat in the output register
    typedef struct packed {
        ps_mty_t mty;                       // lanes padded with zeros
        logic    eop;                       // beat closes a fragment
    } ps_beat_info_t;

endpackage : ps_stream_pkg

// ==== hdl/ps_width_expander.sv ====
`timescale 1ns/100ps

module ps_width_expander
    import ps_stream_pkg::*;
#(
    parameter int WIDTH = 8,                // narrow word width
    parameter int COUNT = 8                 // words per wide beat
) (
    input  logic                     clk,
    input  logic                     i_arst_n,

    input  logic [WIDTH-1:0]         i_dat,
    input  logic                     i_val,
    input  logic                     i_eop,
    output logic                     i_rdy,

    output logic [COUNT*WIDTH-1:0]   o_dat,
    output ps_mty_t                  o_mty,
    output logic                     o_val,
    output logic                     o_eop,
    input  logic                     o_rdy
);

    localparam int LW = $clog2(COUNT);

    logic [LW-1:0]                   lane_cnt;  // next lane to fill
    logic [COUNT-1:0][WIDTH-1:0]     acc;       // gathered lanes
    logic [COUNT-1:0][WIDTH-1:0]     beat;
    logic [COUNT-1:0][WIDTH-1:0]     beat_r;    // output register
    ps_beat_info_t                   info;
    ps_beat_info_t                   info_r;
    logic                            o_val_r;
    logic                            i_xfer;
    logic                            close;

    assign i_rdy  = ~o_val_r | o_rdy;       // one beat deep
    assign i_xfer = i_val & i_rdy;
    assign close  = i_eop | (lane_cnt == LW'(COUNT - 1));

    // beat as it would be loaded, lanes above the new word are zero
    always_comb begin
        for (int l = 0; l < COUNT; l++) begin
            if (l < int'(lane_cnt))
                beat[l] = acc[l];
            else if (l == int'(lane_cnt))
                beat[l] = i_dat;
            else
                beat[l] = '0;
        end
        info.mty = ps_mty_t'(COUNT - 1 - int'(lane_cnt));
        info.eop = i_eop;
    end

    // ------------------------------
    // lane gather and output register
    // ------------------------------
    always_ff @(posedge clk) begin
        if (i_xfer) begin
            acc[lane_cnt] <= i_dat;
            if (close) begin
                beat_r <= beat;
                info_r <= info;
            end
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            lane_cnt <= '0;
            o_val_r  <= 1'b0;
        end else begin
            if (i_xfer)
                lane_cnt <= close ? '0 : lane_cnt + 1'b1;
            if (i_xfer && close)
                o_val_r <= 1'b1;
            else if (o_rdy)
                o_val_r <= 1'b0;            // beat taken
        end
    end

    assign o_dat = beat_r;
    assign o_mty = info_r.mty;
    assign o_eop = info_r.eop;
    assign o_val = o_val_r;

endmodule : ps_width_expander

// ==== sources.f ====
hdl/ps_stream_pkg.sv
hdl/ps_frag_pkg.sv
hdl/ps_fragmenter_packer.sv
hdl/ps_width_expander.sv
hdl/ds_width_divider.sv
hdl/ps_defragmenter_unpacker.sv
hdl/ps_frag_link.sv
dv/ps_frag_link_tb.sv
